// File: vlog.f
+incdir+logic
logic/huff_sym_pkg.sv
logic/huff_ctrl_pkg.sv
logic/symbol_histogram.sv
logic/huff_tree_builder.sv
logic/code_assembler.sv
logic/huff_sequencer.sv
logic/huffman_top.sv
verif/huffman_props.sv
verif/huffman_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the huffman testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module huffman_tb \
	&& ./obj_dir/Vhuffman_tb > sim.log 2>&1 \
	|| echo "verilator build or simulation returned an error" >> sim.log

cat sim.log
grep -q "All tests passed" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// File: verif/huffman_tb.sv
`include "huff_params.svh"

module huffman_tb import huff_sym_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	// six streams of 255 bytes and 30 cycles each need 1710 cycles plus margin
	localparam int cycle_limit = 3000;

	// longest build and assign of a full six-leaf tree
	localparam int code_latency_max = 14;

	logic                    clk = 1'b0;
	logic                    reset;
	logic                    gray_valid;
	logic [`HUFF_DATA_W-1:0] gray_data;
	logic                    cnt_valid;
	sym_counts_t             cnt;
	logic                    code_valid;
	code_table_t             codes;

	logic [`HUFF_DATA_W-1:0] stream_q[$];
	logic [31:0]             lcg_state = 32'd57858;
	int                      cycle_count = 0;
	int                      cnt_valid_pulses = 0;
	int                      errors = 0;
	int                      test_errors = 0;
	int                      tests_failed = 0;
	int                      tests_run = 0;

	huffman_top UUT (.*);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= cycle_limit) begin
			$display("timeout after %0d cycles, the tests did not complete", cycle_count);
			$display("Some tests failed");
			$finish;
		end
	end

	// cnt_valid cycles since the last reset
	always @(negedge clk) begin
		if (reset) begin
			cnt_valid_pulses = 0;
		end else if (cnt_valid) begin
			cnt_valid_pulses++;
		end
	end

	// ==================================================
	// reference model
	// ==================================================

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// lighter first and then the smaller member mask
	function automatic logic precedes(count_t wa, sym_mask_t ma, count_t wb, sym_mask_t mb);
		if (wa != wb) begin
			return wa < wb;
		end
		return ma < mb;
	endfunction

	function automatic sym_counts_t model_counts();
		sym_counts_t c;
		int          sym;
		c = '0;
		foreach (stream_q[i]) begin
			sym = int'(stream_q[i]);
			if (sym >= 1 && sym <= `HUFF_NUM_SYMBOLS) begin
				c[sym - 1] = c[sym - 1] + count_t'(1);
			end
		end
		return c;
	endfunction

	function automatic code_table_t model_codes(sym_counts_t counts);
		count_t      w[`HUFF_NUM_SYMBOLS];
		sym_mask_t   m[`HUFF_NUM_SYMBOLS];
		sym_mask_t   ones[`HUFF_MAX_MERGES];
		sym_mask_t   zeros[`HUFF_MAX_MERGES];
		code_table_t result;
		int          n;
		int          a;
		int          b;
		result = '0;
		n = 0;
		for (int k = 0; k < `HUFF_NUM_SYMBOLS; k++) begin
			w[k] = counts[k];
			m[k] = sym_mask_t'(1 << k);
		end
		for (int step = 0; step < `HUFF_MAX_MERGES; step++) begin
			a = -1;
			b = -1;
			// single pass keeps the best two
			for (int k = 0; k < `HUFF_NUM_SYMBOLS; k++) begin
				if (w[k] != '0) begin
					if (a < 0 || precedes(w[k], m[k], w[a], m[a])) begin
						b = a;
						a = k;
					end else if (b < 0 || precedes(w[k], m[k], w[b], m[b])) begin
						b = k;
					end
				end
			end
			if (b >= 0) begin
				ones[n] = m[a];
				zeros[n] = m[b];
				w[a] = w[a] + w[b];
				m[a] = m[a] | m[b];
				w[b] = '0;
				n++;
			end
		end
		// last merge ends up as the top used bit
		for (int r = n - 1; r >= 0; r--) begin
			for (int k = 0; k < `HUFF_NUM_SYMBOLS; k++) begin
				if (ones[r][k] || zeros[r][k]) begin
					result[k].code = {result[k].code[`HUFF_CODE_W-2:0], ones[r][k]};
					result[k].mask = {result[k].mask[`HUFF_CODE_W-2:0], 1'b1};
				end
			end
		end
		return result;
	endfunction

	// ==================================================
	// drive and check
	// ==================================================

	function automatic void push_symbol(int value, int times);
		repeat (times) begin
			stream_q.push_back(`HUFF_DATA_W'(value));
		end
	endfunction

	task automatic check_value(string name, logic [127:0] expected, logic [127:0] actual);
		assert (actual === expected) else begin
			$display("MISMATCH time=%0t %s expected=%0h actual=%0h",
				$time, name, expected, actual);
			test_errors++;
		end
	endtask

	task automatic apply_reset();
		@(posedge clk);
		#2;
		reset = 1'b1;
		gray_valid = 1'b0;
		gray_data = '0;
		repeat (10) @(posedge clk);
		#2;
		reset = 1'b0;
		@(negedge clk);
		assert (!cnt_valid && !code_valid && cnt == '0 && codes == '0) else begin
			$display("outputs were not cleared by reset at time %0t", $time);
			test_errors++;
		end
	endtask

	// reset, send stream_q, then check counts and codes against the model
	task automatic run_stream();
		sym_counts_t exp_cnt;
		code_table_t exp_codes;
		int          waited;
		exp_cnt = model_counts();
		exp_codes = model_codes(exp_cnt);
		apply_reset();
		foreach (stream_q[i]) begin
			@(posedge clk);
			#2;
			gray_valid = 1'b1;
			gray_data = stream_q[i];
		end
		@(posedge clk);
		#2;
		gray_valid = 1'b0;
		gray_data = '0;
		waited = 0;
		@(negedge clk);
		while (!cnt_valid && waited < 4) begin
			@(negedge clk);
			waited++;
		end
		// the pulse belongs to the cycle after the first low gray_valid
		assert (cnt_valid && waited == 1) else begin
			$display("cnt_valid did not pulse in the cycle after the stream ended");
			test_errors++;
		end
		check_value("cnt", 128'(exp_cnt), 128'(cnt));
		waited = 0;
		while (!code_valid && waited < code_latency_max) begin
			@(negedge clk);
			waited++;
		end
		assert (code_valid) else begin
			$display("code_valid did not rise within %0d cycles of cnt_valid",
				code_latency_max);
			test_errors++;
		end
		check_value("codes", 128'(exp_codes), 128'(codes));
		assert (cnt_valid_pulses == 1) else begin
			$display("cnt_valid was high in %0d cycles instead of exactly one",
				cnt_valid_pulses);
			test_errors++;
		end
	endtask

	task automatic end_test(string name);
		tests_run++;
		errors += test_errors;
		if (test_errors != 0) begin
			tests_failed++;
		end
		$display("%s: %s, %0d errors", name, (test_errors == 0) ? "ok" : "FAILED", test_errors);
		test_errors = 0;
	endtask

	// ==================================================
	// tests
	// ==================================================

	task automatic test_histogram();
		stream_q.delete();
		push_symbol(3, 4);
		push_symbol(1, 2);
		push_symbol(6, 5);
		push_symbol(2, 1);
		push_symbol(5, 3);
		push_symbol(4, 2);
		run_stream();
		end_test("histogram");
	endtask

	task automatic test_invalid_bytes();
		stream_q.delete();
		push_symbol(3, 4);
		push_symbol(0, 2);
		push_symbol(1, 2);
		push_symbol(7, 1);
		push_symbol(6, 5);
		push_symbol(200, 3);
		push_symbol(2, 1);
		push_symbol(5, 3);
		push_symbol(4, 2);
		run_stream();
		end_test("invalid_bytes");
	endtask

	task automatic test_distinct_weights();
		stream_q.delete();
		for (int k = 1; k <= `HUFF_NUM_SYMBOLS; k++) begin
			push_symbol(k, k);
		end
		run_stream();
		// codes must hold until the next reset
		repeat (20) begin
			@(negedge clk);
			check_value("code_valid", 128'(1), 128'(code_valid));
		end
		end_test("distinct_weights");
	endtask

	task automatic test_equal_weights();
		stream_q.delete();
		for (int k = `HUFF_NUM_SYMBOLS; k >= 1; k--) begin
			push_symbol(k, 2);
		end
		run_stream();
		end_test("equal_weights");
	endtask

	task automatic test_absent_symbols();
		stream_q.delete();
		push_symbol(1, 3);
		push_symbol(3, 1);
		push_symbol(4, 2);
		push_symbol(6, 5);
		run_stream();
		check_value("codes[1]", 128'(0), 128'(codes[1]));
		check_value("codes[4]", 128'(0), 128'(codes[4]));
		// a lone symbol leaves nothing to merge
		stream_q.delete();
		push_symbol(3, 6);
		run_stream();
		check_value("codes", 128'(0), 128'(codes));
		end_test("absent_symbols");
	endtask

	task automatic test_random_streams();
		int len;
		for (int s = 0; s < 3; s++) begin
			stream_q.delete();
			len = 1 + int'((lcg_next() >> 16) % 200);
			repeat (len) begin
				stream_q.push_back(`HUFF_DATA_W'((lcg_next() >> 16) % 8));
			end
			run_stream();
		end
		end_test("random_streams");
	endtask

	initial begin
		reset = 1'b1;
		gray_valid = 1'b0;
		gray_data = '0;
		test_histogram();
		test_invalid_bytes();
		test_distinct_weights();
		test_equal_weights();
		test_absent_symbols();
		test_random_streams();
		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// File: verif/huffman_props.sv
module huffman_props (
	input logic clk,
	input logic reset,
	input logic cnt_valid,
	input logic code_valid
);

	timeunit 1ns;
	timeprecision 1ps;

	// ==================================================
	// control flag rules
	// ==================================================

	// count strobe is a single cycle
	assert property (@(posedge clk) disable iff (reset) cnt_valid |=> !cnt_valid)
		else $error("cnt_valid held for more than one cycle");

	// codes stay valid until the next reset
	assert property (@(posedge clk) disable iff (reset) code_valid |=> code_valid)
		else $error("code_valid fell without reset");

	assert property (@(posedge clk) reset |=> !cnt_valid && !code_valid)
		else $error("flags not low in the cycle after reset");

endmodule

bind huffman_top huffman_props u_props (.*);

// File: logic/huffman_top.sv
`include "huff_params.svh"

module huffman_top
	import huff_sym_pkg::*;
	import huff_ctrl_pkg::*;
(
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    gray_valid,
	input  logic [`HUFF_DATA_W-1:0] gray_data,
	output logic                    cnt_valid,
	output sym_counts_t             cnt,
	output logic                    code_valid,
	output code_table_t             codes
);

	logic count_enable;
	logic build_start;
	logic build_done;
	logic assign_start;
	logic assign_done;

	logic [$clog2(`HUFF_MAX_MERGES + 1)-1:0] merge_count;
	merge_rec_t [`HUFF_MAX_MERGES-1:0]       merge_log;

	symbol_histogram u_hist (
		.clk          (clk),
		.reset        (reset),
		.count_enable (count_enable),
		.gray_valid   (gray_valid),
		.gray_data    (gray_data),
		.cnt          (cnt)
	);

	huff_tree_builder u_builder (
		.clk         (clk),
		.reset       (reset),
		.build_start (build_start),
		.cnt         (cnt),
		.build_done  (build_done),
		.merge_count (merge_count),
		.merge_log   (merge_log)
	);

	code_assembler u_assembler (
		.clk          (clk),
		.reset        (reset),
		.assign_start (assign_start),
		.merge_count  (merge_count),
		.merge_log    (merge_log),
		.assign_done  (assign_done),
		.codes        (codes)
	);

	huff_sequencer u_seq (
		.clk          (clk),
		.reset        (reset),
		.gray_valid   (gray_valid),
		.build_done   (build_done),
		.assign_done  (assign_done),
		.count_enable (count_enable),
		.cnt_valid    (cnt_valid),
		.build_start  (build_start),
		.assign_start (assign_start),
		.code_valid   (code_valid)
	);

endmodule

// File: logic/huff_sequencer.sv
module huff_sequencer import huff_ctrl_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic gray_valid,
	input  logic build_done,
	input  logic assign_done,
	output logic count_enable,
	output logic cnt_valid,
	output logic build_start,
	output logic assign_start,
	output logic code_valid
);

	huff_phase_t phase;
	huff_phase_t phase_next;

	// ==================================================
	// phase register
	// ==================================================

	always_ff @(posedge clk) begin
		if (reset) begin
			phase <= ph_idle;
		end else begin
			phase <= phase_next;
		end
	end

	always_comb begin
		phase_next = phase;
		case (phase)
			ph_idle: begin
				if (gray_valid) begin
					phase_next = ph_receive;
				end
			end
			// stream ends on the first low gray_valid
			ph_receive: begin
				if (!gray_valid) begin
					phase_next = ph_count_out;
				end
			end
			ph_count_out: phase_next = ph_build;
			ph_build: begin
				if (build_done) begin
					phase_next = ph_assign;
				end
			end
			ph_assign: begin
				if (assign_done) begin
					phase_next = ph_done;
				end
			end
			// held until reset
			ph_done: phase_next = ph_done;
			default: phase_next = ph_idle;
		endcase
	end

	// ==================================================
	// strobes
	// ==================================================

	// first byte arrives while still idle
	assign count_enable = (phase == ph_idle) || (phase == ph_receive);
	assign cnt_valid    = phase == ph_count_out;
	assign build_start  = phase == ph_count_out;
	assign assign_start = (phase == ph_build) && build_done;
	assign code_valid   = phase == ph_done;

endmodule

// File: logic/code_assembler.sv
`include "huff_params.svh"

module code_assembler
	import huff_sym_pkg::*;
	import huff_ctrl_pkg::*;
(
	input  logic                                    clk,
	input  logic                                    reset,
	input  logic                                    assign_start,
	input  logic [$clog2(`HUFF_MAX_MERGES + 1)-1:0] merge_count,
	input  merge_rec_t [`HUFF_MAX_MERGES-1:0]       merge_log,
	output logic                                    assign_done,
	output code_table_t                             codes
);

	localparam int mc_w = $clog2(`HUFF_MAX_MERGES + 1);

	logic            busy;
	logic [mc_w-1:0] ptr;
	logic            step;
	merge_rec_t      cur_rec;

	// ptr counts the records still to be applied, newest first
	assign cur_rec     = merge_log[ptr - mc_w'(1)];
	assign step        = busy && (ptr != '0);
	assign assign_done = busy && (ptr == '0);

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			ptr  <= '0;
		end else if (assign_start) begin
			busy <= 1'b1;
			ptr  <= merge_count;
		end else if (step) begin
			ptr <= ptr - mc_w'(1);
		end else if (assign_done) begin
			busy <= 1'b0;
		end
	end

	// shift one bit into each member of the current record
	always_ff @(posedge clk) begin
		if (reset || assign_start) begin
			codes <= '0;
		end else if (step) begin
			for (int k = 0; k < `HUFF_NUM_SYMBOLS; k++) begin
				if (cur_rec.one_mask[k]) begin
					codes[k].code <= {codes[k].code[`HUFF_CODE_W-2:0], 1'b1};
					codes[k].mask <= {codes[k].mask[`HUFF_CODE_W-2:0], 1'b1};
				end else if (cur_rec.zero_mask[k]) begin
					codes[k].code <= {codes[k].code[`HUFF_CODE_W-2:0], 1'b0};
					codes[k].mask <= {codes[k].mask[`HUFF_CODE_W-2:0], 1'b1};
				end
			end
		end
	end

endmodule

// File: logic/huff_tree_builder.sv
`include "huff_params.svh"

module huff_tree_builder
	import huff_sym_pkg::*;
	import huff_ctrl_pkg::*;
(
	input  logic                                        clk,
	input  logic                                        reset,
	input  logic                                        build_start,
	input  sym_counts_t                                 cnt,
	output logic                                        build_done,
	output logic [$clog2(`HUFF_MAX_MERGES + 1)-1:0]     merge_count,
	output merge_rec_t [`HUFF_MAX_MERGES-1:0]           merge_log
);

	localparam int mc_w  = $clog2(`HUFF_MAX_MERGES + 1);
	localparam int idx_w = $clog2(`HUFF_NUM_SYMBOLS);

	huff_node_t [`HUFF_NUM_SYMBOLS-1:0] node;
	sym_mask_t                          live;
	logic                               busy;

	logic [idx_w-1:0] first_idx;
	logic [idx_w-1:0] second_idx;
	logic             first_ok;
	logic             second_ok;
	logic             do_merge;

	count_t    merged_weight;
	sym_mask_t merged_mask;

	// lighter weight first, equal weights fall back to the smaller mask
	function automatic logic ranks_before(huff_node_t a, huff_node_t b);
		return (a.weight < b.weight) ||
			((a.weight == b.weight) && (a.members < b.members));
	endfunction

	always_comb begin
		for (int k = 0; k < `HUFF_NUM_SYMBOLS; k++) begin
			live[k] = node[k].weight != '0;
		end
	end

	// ==================================================
	// two-smallest search
	// ==================================================

	always_comb begin
		first_idx  = '0;
		second_idx = '0;
		first_ok   = 1'b0;
		second_ok  = 1'b0;
		for (int i = 0; i < `HUFF_NUM_SYMBOLS; i++) begin
			if (live[i] && (!first_ok || ranks_before(node[i], node[first_idx]))) begin
				first_idx = idx_w'(i);
				first_ok  = 1'b1;
			end
		end
		// same scan again, skipping the winner
		for (int i = 0; i < `HUFF_NUM_SYMBOLS; i++) begin
			if (live[i] && (idx_w'(i) != first_idx) &&
				(!second_ok || ranks_before(node[i], node[second_idx]))) begin
				second_idx = idx_w'(i);
				second_ok  = 1'b1;
			end
		end
	end

	assign merged_weight = node[first_idx].weight + node[second_idx].weight;
	assign merged_mask   = node[first_idx].members | node[second_idx].members;

	// a merge needs two live nodes, otherwise the tree is complete
	assign do_merge   = busy && second_ok;
	assign build_done = busy && !second_ok;

	// ==================================================
	// control
	// ==================================================

	always_ff @(posedge clk) begin
		if (reset) begin
			busy        <= 1'b0;
			merge_count <= '0;
		end else if (build_start) begin
			busy        <= 1'b1;
			merge_count <= '0;
		end else if (do_merge) begin
			merge_count <= merge_count + mc_w'(1);
		end else if (build_done) begin
			busy <= 1'b0;
		end
	end

	// ==================================================
	// node slots and merge log
	// ==================================================

	always_ff @(posedge clk) begin
		if (build_start) begin
			for (int k = 0; k < `HUFF_NUM_SYMBOLS; k++) begin
				node[k].weight  <= cnt[k];
				node[k].members <= sym_mask_t'(1) << k;
			end
		end else if (do_merge) begin
			// merged node takes the first slot, the second slot goes empty
			node[first_idx].weight  <= merged_weight;
			node[first_idx].members <= merged_mask;
			node[second_idx]        <= '0;
			merge_log[merge_count].one_mask  <= node[first_idx].members;
			merge_log[merge_count].zero_mask <= node[second_idx].members;
		end
	end

endmodule

// File: logic/symbol_histogram.sv
`include "huff_params.svh"

module symbol_histogram import huff_sym_pkg::*; (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    count_enable,
	input  logic                    gray_valid,
	input  logic [`HUFF_DATA_W-1:0] gray_data,
	output sym_counts_t             cnt
);

	sym_mask_t hit;

	// one-hot decode of the byte value, anything outside 1..6 hits nothing
	always_comb begin
		hit = '0;
		for (int k = 0; k < `HUFF_NUM_SYMBOLS; k++) begin
			if (gray_data == `HUFF_DATA_W'(k + 1)) begin
				hit[k] = 1'b1;
			end
		end
	end

	// counters
	always_ff @(posedge clk) begin
		if (reset) begin
			cnt <= '0;
		end else if (count_enable && gray_valid) begin
			for (int k = 0; k < `HUFF_NUM_SYMBOLS; k++) begin
				if (hit[k]) begin
					cnt[k] <= cnt[k] + `HUFF_COUNT_W'(1);
				end
			end
		end
	end

endmodule

// File: logic/huff_ctrl_pkg.sv
package huff_ctrl_pkg;

	import huff_sym_pkg::*;

	// sequencer phases
	typedef enum logic [2:0] {
		ph_idle,
		ph_receive,
		ph_count_out,
		ph_build,
		ph_assign,
		ph_done
	} huff_phase_t;

	// one merge step of the tree
	// one_mask is the first-ranked side and takes bit 1
	typedef struct packed {
		sym_mask_t one_mask;
		sym_mask_t zero_mask;
	} merge_rec_t;

endpackage

// File: logic/huff_sym_pkg.sv
package huff_sym_pkg;

	`include "huff_params.svh"

	// ==================================================
	// symbols and counts
	// ==================================================

	// bit k stands for symbol k+1
	typedef logic [`HUFF_NUM_SYMBOLS-1:0] sym_mask_t;

	typedef logic [`HUFF_COUNT_W-1:0] count_t;

	// indexed by symbol minus one
	typedef count_t [`HUFF_NUM_SYMBOLS-1:0] sym_counts_t;

	// tree node, zero weight means the slot is empty
	typedef struct packed {
		count_t    weight;
		sym_mask_t members;
	} huff_node_t;

	// ==================================================
	// code output
	// ==================================================

	typedef struct packed {
		logic [`HUFF_CODE_W-1:0] code;
		logic [`HUFF_CODE_W-1:0] mask;
	} code_word_t;

	typedef code_word_t [`HUFF_NUM_SYMBOLS-1:0] code_table_t;

endpackage

// File: logic/huff_params.svh
`ifndef HUFF_PARAMS_SVH
`define HUFF_PARAMS_SVH

// ==================================================
// coder dimensions
// ==================================================

// symbols 1..6 on the input stream
`define HUFF_NUM_SYMBOLS 6

// byte width of gray_data
`define HUFF_DATA_W 8

// counts and node weights, stream length is at most 255
`define HUFF_COUNT_W 8

// code word and length mask width
`define HUFF_CODE_W 8

// a full tree of six leaves needs five merges
`define HUFF_MAX_MERGES 5

`endif
